/* irq_subsys.f */
hdl/irq_pkg.sv
hdl/irq_cfg_regs.sv
hdl/irq_source_channel.sv
hdl/irq_priority_arb.sv
hdl/int_service_ctrl.sv
hdl/irq_subsys.sv
sim/irq_clk_gen.sv
sim/irq_subsys_assertions.sv
sim/irq_subsys_tb.sv

/* sim/irq_subsys_tb.sv */
module irq_subsys_tb;

  timeunit 1ns;
  timeprecision 1ns;

  localparam int NUM_ROWS        = 8;
  localparam int CLK_NS          = 100;
  localparam int ROW_CYCLES      = 200;   // budget per row for the watchdog
  localparam int ROW_LIMIT       = 180;   // a row gives up after this many cycles
  localparam int QUIET           = 30;    // cycles without jal_req that end a row
  localparam int LATE_CYC        = 40;    // cycle of the mid row enable write
  localparam int WATCHDOG_CYCLES = NUM_ROWS * ROW_CYCLES + 40;   // plus reset

  // one stimulus row
  typedef struct packed {
    irq_pkg::irq_mask_t enable;       // written at row start
    irq_pkg::irq_mask_t late_enable;  // written at LATE_CYC, 0 = no write
    irq_pkg::irq_mask_t level_mode;
    irq_pkg::irq_vec_t  base;
    irq_pkg::irq_mask_t src;          // lines raised at row start
    logic [7:0]         hold_svcs;    // level lines dropped after this many, 0 = held
    logic [7:0]         halt_start;   // row cycle where halt goes high
    logic [7:0]         halt_len;     // 0 = no halt
    logic               nop_rand;     // random nop_detect, else held high
  } row_t;

  logic               clk;
  logic               reset_b;
  logic               cfg_wr;
  irq_pkg::cfg_addr_t cfg_addr;
  irq_pkg::cfg_word_t cfg_wdata;
  irq_pkg::irq_mask_t irq_src;
  logic               halt;
  logic               nop_detect;
  logic               int_rdy;
  logic               idle;
  logic               jal_req;
  logic               int_busy;
  irq_pkg::irq_vec_t  jal_vector;

  row_t              table_rows [NUM_ROWS];
  string             row_name [NUM_ROWS];
  irq_pkg::irq_vec_t exp_q [$];   // vectors the current row should produce, in order
  int                checks;
  int                errors;
  integer            seed;

  irq_clk_gen u_clk (
    .clk     (clk),
    .reset_b (reset_b)
  );

  irq_subsys UUT (
    .clk        (clk),
    .reset_b    (reset_b),
    .cfg_wr     (cfg_wr),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .irq_src    (irq_src),
    .halt       (halt),
    .nop_detect (nop_detect),
    .int_rdy    (int_rdy),
    .idle       (idle),
    .jal_req    (jal_req),
    .int_busy   (int_busy),
    .jal_vector (jal_vector)
  );

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR at %0t ns: %s", $time, msg);
  endtask

  task automatic set_row(input int idx, input string name, input irq_pkg::irq_mask_t en,
                         input irq_pkg::irq_mask_t late, input irq_pkg::irq_mask_t mode,
                         input irq_pkg::irq_vec_t base, input irq_pkg::irq_mask_t src,
                         input int hold, input int hs, input int hl, input logic rnd);
    row_name[idx]              = name;
    table_rows[idx].enable      = en;
    table_rows[idx].late_enable = late;
    table_rows[idx].level_mode  = mode;
    table_rows[idx].base        = base;
    table_rows[idx].src         = src;
    table_rows[idx].hold_svcs   = hold[7:0];
    table_rows[idx].halt_start  = hs[7:0];
    table_rows[idx].halt_len    = hl[7:0];
    table_rows[idx].nop_rand    = rnd;
  endtask

  task automatic load_table();
    //       row name           enable late   mode   base      src    hold hs  hl  rnd
    set_row(0, "no source",     8'hff, 8'h00, 8'h00, 16'h0010, 8'h00, 0,   0,  0,  1'b0);
    set_row(1, "single edge",   8'h04, 8'h00, 8'h00, 16'h0100, 8'h04, 0,   0,  0,  1'b0);
    set_row(2, "priority",      8'hff, 8'h00, 8'h00, 16'h0200, 8'ha5, 0,   0,  0,  1'b0);
    set_row(3, "enable mask",   8'h00, 8'h08, 8'h00, 16'h0300, 8'h48, 0,   0,  0,  1'b0);
    set_row(4, "edge held",     8'h02, 8'h00, 8'h00, 16'h0400, 8'h02, 0,   0,  0,  1'b0);
    set_row(5, "level held",    8'h01, 8'h00, 8'h01, 16'h0500, 8'h01, 3,   0,  0,  1'b0);
    set_row(6, "nop gaps",      8'h20, 8'h00, 8'h00, 16'h0600, 8'h20, 0,   0,  0,  1'b1);
    set_row(7, "halt",          8'h10, 8'h00, 8'h00, 16'h0700, 8'h10, 0,   6,  12, 1'b0);
  endtask

  // reference model: lines that end up enabled are served lowest index first
  function automatic void build_expected(input row_t r);
    irq_pkg::irq_mask_t en;
    int                 reps;
    exp_q.delete();
    en = (r.late_enable != '0) ? r.late_enable : r.enable;   // latch survives the mask
    for (int i = 0; i < irq_pkg::NUM_IRQ; i++)
    begin
      if (r.src[i] && en[i])
      begin
        // a held level line re-latches during each service, one more after the drop
        reps = (r.level_mode[i] && r.hold_svcs != 0) ? int'(r.hold_svcs) + 1 : 1;
        repeat (reps) exp_q.push_back(r.base + irq_pkg::irq_vec_t'(i));
      end
    end
  endfunction

  // one strobed write, called and returning on a falling edge
  task automatic cfg_write(input irq_pkg::cfg_addr_t addr, input irq_pkg::cfg_word_t data);
    cfg_wr    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(negedge clk);
    cfg_wr    = 1'b0;
  endtask

  task automatic run_row(input int idx);
    row_t               r;
    irq_pkg::irq_mask_t cur_src;
    int                 c;
    int                 svc;
    int                 last_c;
    int                 nops_seen;   // nops the DUT should have counted so far
    int                 err0;
    int                 hs;
    int                 he;
    logic               jal_prev;
    logic               halt_prev;
    logic               done;
    logic [2:0]         snap;        // idle, jal_req, int_busy before a halt
    logic [31:0]        rnd;
    r         = table_rows[idx];
    err0      = errors;
    cur_src   = r.src;
    c         = 0;
    svc       = 0;
    last_c    = 0;
    nops_seen = 0;
    jal_prev  = 1'b0;
    halt_prev = 1'b0;
    done      = 1'b0;
    snap      = '0;
    hs        = int'(r.halt_start);
    he        = hs + int'(r.halt_len);
    cfg_write(irq_pkg::CFG_ENABLE, irq_pkg::cfg_word_t'(r.enable));
    cfg_write(irq_pkg::CFG_MODE, irq_pkg::cfg_word_t'(r.level_mode));
    cfg_write(irq_pkg::CFG_BASE, r.base);
    build_expected(r);
    while (!done && c < ROW_LIMIT)
    begin
      // outputs first, they settled after the last rising edge
      if (jal_req && !jal_prev)
      begin
        if (r.late_enable != '0 && c <= LATE_CYC)
          report_error($sformatf("row %0d serviced a line that was still disabled", idx));
        if (svc < exp_q.size())
          check_value("jal_vector", jal_vector, exp_q[svc]);
        else
          report_error($sformatf("row %0d got an extra jal_req, vector %0h", idx, jal_vector));
        check_value("nops before jal_req", nops_seen, irq_pkg::NOP_WAIT);
        nops_seen = 0;
        svc++;
        last_c = c;
        if (r.hold_svcs != 0 && svc == int'(r.hold_svcs))
          cur_src = cur_src & ~r.level_mode;   // drop the level lines
      end
      jal_prev = jal_req;
      if (halt_prev)
        check_value("{idle,jal_req,int_busy} under halt", {idle, jal_req, int_busy}, snap);
      else
        snap = {idle, jal_req, int_busy};
      irq_src = cur_src;
      halt    = (c >= hs) && (c < he);
      if (r.nop_rand)
      begin
        rnd        = $random(seed);
        nop_detect = rnd[0];
      end
      else
        nop_detect = 1'b1;
      if (r.late_enable != '0 && c == LATE_CYC)
      begin
        cfg_wr    = 1'b1;   // unmask the line that was raised while disabled
        cfg_addr  = irq_pkg::CFG_ENABLE;
        cfg_wdata = irq_pkg::cfg_word_t'(r.late_enable);
      end
      else
        cfg_wr = 1'b0;
      if (idle && nop_detect && !halt)
        nops_seen++;        // counted at the coming rising edge
      halt_prev = halt;
      done = (svc >= exp_q.size()) && (c - last_c >= QUIET) && !int_busy
             && (r.late_enable == '0 || c > LATE_CYC);
      c++;
      @(negedge clk);
    end
    if (!done)
      report_error($sformatf("row %0d gave up after %0d cycles, %0d of %0d jal_req seen",
                             idx, c, svc, exp_q.size()));
    irq_src    = '0;
    halt       = 1'b0;
    nop_detect = 1'b0;
    cfg_wr     = 1'b0;
    repeat (4) @(negedge clk);   // let the synchronizers drain
    $display("row %0d %-12s %0d of %0d services, %0s", idx, row_name[idx], svc, exp_q.size(),
             (errors == err0) ? "ok" : "errors");
  endtask

  initial
  begin
    seed       = 32'hd498b65a;
    checks     = 0;
    errors     = 0;
    cfg_wr     = 1'b0;
    cfg_addr   = '0;
    cfg_wdata  = '0;
    irq_src    = '0;
    halt       = 1'b0;
    nop_detect = 1'b0;
    load_table();
    wait (reset_b === 1'b1);
    @(negedge clk);
    check_value("int_rdy", int_rdy, 1);
    check_value("idle", idle, 0);
    check_value("jal_req", jal_req, 0);
    check_value("int_busy", int_busy, 0);
    check_value("jal_vector", jal_vector, 0);
    $display("reset values %0s", (errors == 0) ? "ok" : "errors");
    for (int i = 0; i < NUM_ROWS; i++)
      run_row(i);
    $display("tests %0d, checks %0d, errors %0d", NUM_ROWS + 1, checks, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  // ends a hung run
  initial
  begin
    #(WATCHDOG_CYCLES * CLK_NS);
    $display("ERROR: watchdog expired, run took longer than %0d cycles", WATCHDOG_CYCLES);
    $display("** FAIL **");
    $finish;
  end

endmodule

/* sim/irq_subsys_assertions.sv */
module irq_subsys_assertions (
  input logic               clk,
  input logic               reset_b,
  input logic               halt,
  input logic               idle,
  input logic               jal_req,
  input irq_pkg::irq_mask_t clear     // arbiter clear vector, internal to the top
);

  timeunit 1ns;
  timeprecision 1ns;

  // jal is a single cycle unless halt freezes the state machine in SVC_JAL
  a_jal_one_cycle : assert property (@(posedge clk) disable iff (!reset_b)
    jal_req && !halt |=> !jal_req)
    else $error("jal_req held high for more than one cycle");

  a_idle_jal_apart : assert property (@(posedge clk) disable iff (!reset_b)
    !(idle && jal_req))
    else $error("idle and jal_req high together");

  // state only moves at an edge where halt was low
  a_idle_rise_halt : assert property (@(posedge clk) disable iff (!reset_b)
    $rose(idle) |-> !$past(halt))
    else $error("idle rose while halt was high");

  a_jal_rise_halt : assert property (@(posedge clk) disable iff (!reset_b)
    $rose(jal_req) |-> !$past(halt))
    else $error("jal_req rose while halt was high");

  a_clear_onehot : assert property (@(posedge clk) disable iff (!reset_b)
    $onehot0(clear))
    else $error("more than one clear bit high");

endmodule

bind irq_subsys irq_subsys_assertions u_assertions (
  .clk     (clk),
  .reset_b (reset_b),
  .halt    (halt),
  .idle    (idle),
  .jal_req (jal_req),
  .clear   (clear)
);

/* sim/irq_clk_gen.sv */
module irq_clk_gen (
  output logic clk,
  output logic reset_b
);

  timeunit 1ns;
  timeprecision 1ns;

  localparam int PERIOD_NS    = 100;
  localparam int RESET_CYCLES = 16;

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // reset released on a falling edge, away from the sampling edge
  initial
  begin
    reset_b = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset_b = 1'b1;
  end

endmodule

/* hdl/irq_subsys.sv */
module irq_subsys (
  input  logic               clk,
  input  logic               reset_b,
  input  logic               cfg_wr,
  input  irq_pkg::cfg_addr_t cfg_addr,
  input  irq_pkg::cfg_word_t cfg_wdata,
  input  irq_pkg::irq_mask_t irq_src,     // raw asynchronous lines
  input  logic               halt,
  input  logic               nop_detect,
  output logic               int_rdy,
  output logic               idle,
  output logic               jal_req,
  output logic               int_busy,
  output irq_pkg::irq_vec_t  jal_vector
);

  irq_pkg::irq_cfg_t  cfg;       // enable, mode and base to everyone
  irq_pkg::irq_mask_t pending;   // already masked by enable
  irq_pkg::irq_mask_t clear;     // one hot from the arbiter
  logic               int_req;
  irq_pkg::irq_vec_t  int_num;

  irq_cfg_regs u_cfg_regs (
    .clk       (clk),
    .reset_b   (reset_b),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg       (cfg)
  );

  // one identical channel per line
  for (genvar i = 0; i < irq_pkg::NUM_IRQ; i++)
  begin : g_chan
    irq_source_channel u_chan (
      .clk        (clk),
      .reset_b    (reset_b),
      .src        (irq_src[i]),
      .enable     (cfg.enable[i]),
      .level_mode (cfg.level_mode[i]),
      .clear      (clear[i]),
      .pending    (pending[i])
    );
  end

  irq_priority_arb u_arb (
    .clk         (clk),
    .reset_b     (reset_b),
    .pending     (pending),
    .vector_base (cfg.vector_base),
    .int_rdy     (int_rdy),
    .clear       (clear),
    .int_req     (int_req),
    .int_num     (int_num)
  );

  // busy flag and serviced vector go straight out
  int_service_ctrl u_svc (
    .clk         (clk),
    .reset_b     (reset_b),
    .halt        (halt),
    .int_req     (int_req),
    .nop_detect  (nop_detect),
    .int_num     (int_num),
    .int_rdy     (int_rdy),
    .idle        (idle),
    .jal_req     (jal_req),
    .int_srv_req (int_busy),
    .int_srv_num (jal_vector)
  );

endmodule

/* hdl/int_service_ctrl.sv */
module int_service_ctrl (
  input  logic              clk,
  input  logic              reset_b,
  input  logic              halt,         // core halted, freezes everything
  input  logic              int_req,      // strobe from the arbiter
  input  logic              nop_detect,   // core just executed a nop
  input  irq_pkg::irq_vec_t int_num,
  output logic              int_rdy,      // a request now would be taken
  output logic              idle,         // tell the core to idle
  output logic              jal_req,      // fetch inserts the jal
  output logic              int_srv_req,  // busy servicing
  output irq_pkg::irq_vec_t int_srv_num   // vector being serviced
);

  irq_pkg::svc_state_t state;
  irq_pkg::svc_state_t next_state;
  irq_pkg::nop_cnt_t   nop_cnt;
  irq_pkg::irq_vec_t   num_q;
  logic                req_seen;   // strobe that arrived during a halt
  logic                nop_hit;
  logic                nop_last;

  assign nop_hit  = nop_detect && !halt;   // nops under halt do not count
  assign nop_last = nop_hit && (nop_cnt == irq_pkg::nop_cnt_t'(irq_pkg::NOP_WAIT - 1));

  assign int_rdy     = (state == irq_pkg::SVC_READY) && !halt && !req_seen;
  assign idle        = (state == irq_pkg::SVC_IDLE);
  assign jal_req     = (state == irq_pkg::SVC_JAL);
  assign int_srv_req = (state != irq_pkg::SVC_READY);
  assign int_srv_num = num_q;

  // keep a strobe that lands while halted so it is not lost
  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
      req_seen <= 1'b0;
    else
      req_seen <= (state == irq_pkg::SVC_READY) && halt && (int_req || req_seen);
  end

  // saturating nop counter, only runs while idling the core
  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
      nop_cnt <= '0;
    else if (state != irq_pkg::SVC_IDLE)
      nop_cnt <= '0;
    else if (nop_hit && !nop_last)
      nop_cnt <= nop_cnt + 1'b1;
  end

  // capture the vector with the strobe
  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
      num_q <= '0;
    else if (int_req)
      num_q <= int_num;
  end

  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
      state <= irq_pkg::SVC_READY;
    else if (!halt)
      state <= next_state;   // state holds under halt
  end

  always_comb
  begin
    next_state = state;
    case (state)
      irq_pkg::SVC_READY:
      begin
        if (int_req || req_seen)
          next_state = irq_pkg::SVC_IDLE;
      end
      irq_pkg::SVC_IDLE:
      begin
        if (nop_last)
          next_state = irq_pkg::SVC_JAL;   // fourth nop counted
      end
      irq_pkg::SVC_JAL:
      begin
        next_state = irq_pkg::SVC_READY;  // jal is a single cycle
      end
      default:
      begin
        next_state = irq_pkg::SVC_READY;
      end
    endcase
  end

endmodule

/* hdl/irq_priority_arb.sv */
module irq_priority_arb (
  input  logic               clk,
  input  logic               reset_b,
  input  irq_pkg::irq_mask_t pending,      // enabled pending lines
  input  irq_pkg::irq_vec_t  vector_base,
  input  logic               int_rdy,      // service controller can take one
  output irq_pkg::irq_mask_t clear,        // one hot, same cycle as int_req
  output logic               int_req,      // one cycle strobe
  output irq_pkg::irq_vec_t  int_num       // valid with int_req
);

  irq_pkg::irq_mask_t sel_mask;   // lowest pending line, one hot
  irq_pkg::irq_idx_t  sel_idx;
  logic               grant;

  // isolate the lowest set bit, line 0 has top priority
  assign sel_mask = pending & ~(pending - 1'b1);

  // encode the one hot pick into a line index
  always_comb
  begin
    sel_idx = '0;
    for (int i = 0; i < irq_pkg::NUM_IRQ; i++)
    begin
      if (sel_mask[i])
        sel_idx = irq_pkg::irq_idx_t'(i);
    end
  end

  // own strobe blocks a second grant while int_rdy has not dropped yet
  assign grant = int_rdy && !int_req && (|pending);

  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
    begin
      int_req <= 1'b0;
      clear   <= '0;
    end
    else
    begin
      int_req <= grant;
      clear   <= grant ? sel_mask : '0;   // drops the granted line's latch
    end
  end

  // vector = base + index of the granted line
  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
      int_num <= '0;
    else if (grant)
      int_num <= vector_base + irq_pkg::irq_vec_t'(sel_idx);
  end

endmodule

/* hdl/irq_source_channel.sv */
module irq_source_channel (
  input  logic clk,
  input  logic reset_b,
  input  logic src,         // asynchronous request line
  input  logic enable,      // from the enable mask
  input  logic level_mode,  // 1 = level, 0 = rising edge
  input  logic clear,       // one cycle clear from the arbiter
  output logic pending
);

  logic sync_1;     // first synchronizer stage
  logic sync_2;     // synchronized line
  logic sync_prev;  // sync_2 one cycle late, for edge detect
  logic pend_q;     // latched request
  logic set;

  // two flop synchronizer plus a delay stage for the edge detector
  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
    begin
      sync_1    <= 1'b0;
      sync_2    <= 1'b0;
      sync_prev <= 1'b0;
    end
    else
    begin
      sync_1    <= src;
      sync_2    <= sync_1;
      sync_prev <= sync_2;
    end
  end

  // level mode sets every cycle the line is high,
  // edge mode only on the first cycle it is seen high
  assign set = level_mode ? sync_2 : (sync_2 && !sync_prev);

  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
      pend_q <= 1'b0;
    else if (clear)
      pend_q <= 1'b0;      // clear beats a set in the same cycle
    else if (set)
      pend_q <= 1'b1;      // new edge on a pending line just merges
  end

  // latch keeps its state while masked, it just is not shown
  assign pending = pend_q && enable;

endmodule

/* hdl/irq_cfg_regs.sv */
module irq_cfg_regs (
  input  logic               clk,
  input  logic               reset_b,
  input  logic               cfg_wr,     // single cycle write strobe
  input  irq_pkg::cfg_addr_t cfg_addr,
  input  irq_pkg::cfg_word_t cfg_wdata,
  output irq_pkg::irq_cfg_t  cfg
);

  irq_pkg::irq_mask_t enable_q;
  irq_pkg::irq_mask_t mode_q;
  irq_pkg::irq_vec_t  base_q;

  // write decode, registers update on the strobe edge
  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
    begin
      enable_q <= '0;   // everything masked out of reset
      mode_q   <= '0;   // edge mode by default
      base_q   <= '0;
    end
    else if (cfg_wr)
    begin
      case (cfg_addr)
        irq_pkg::CFG_ENABLE:
        begin
          enable_q <= cfg_wdata[irq_pkg::NUM_IRQ-1:0];  // low bits only
        end
        irq_pkg::CFG_MODE:
        begin
          mode_q <= cfg_wdata[irq_pkg::NUM_IRQ-1:0];
        end
        irq_pkg::CFG_BASE:
        begin
          base_q <= cfg_wdata;
        end
        default:
        begin
          // address 3 has no register, write dropped
        end
      endcase
    end
  end

  // pack the register set for the channels and arbiter
  always_comb
  begin
    cfg.enable      = enable_q;
    cfg.level_mode  = mode_q;
    cfg.vector_base = base_q;
  end

endmodule

/* hdl/irq_pkg.sv */
package irq_pkg;

  // interrupt line count, anything from 2 to 16 works
  localparam int unsigned NUM_IRQ   = 8;
  localparam int unsigned VEC_W     = 16;   // vector reported to the core
  localparam int unsigned IDX_W     = 4;    // enough for 16 lines
  localparam int unsigned CFG_W     = 16;   // config write data width

  // nops the core must execute before the jal goes in
  localparam int unsigned NOP_WAIT  = 4;
  localparam int unsigned NOP_CNT_W = $clog2(NOP_WAIT);

  typedef logic [VEC_W-1:0]     irq_vec_t;
  typedef logic [IDX_W-1:0]     irq_idx_t;
  typedef logic [NUM_IRQ-1:0]   irq_mask_t;   // one bit per line
  typedef logic [1:0]           cfg_addr_t;
  typedef logic [CFG_W-1:0]     cfg_word_t;
  typedef logic [NOP_CNT_W-1:0] nop_cnt_t;

  // config register map, address 3 unused
  localparam cfg_addr_t CFG_ENABLE = 2'd0;
  localparam cfg_addr_t CFG_MODE   = 2'd1;
  localparam cfg_addr_t CFG_BASE   = 2'd2;

  // config bundle fanned out to channels and arbiter
  typedef struct packed {
    irq_mask_t enable;       // 1 = line may be serviced
    irq_mask_t level_mode;   // 1 = level, 0 = edge
    irq_vec_t  vector_base;  // vector of line 0
  } irq_cfg_t;

  // service controller states
  typedef enum logic [1:0] {
    SVC_READY = 2'd0,   // waiting for a request
    SVC_IDLE  = 2'd1,   // core idled, counting nops
    SVC_JAL   = 2'd2    // one cycle jal insertion
  } svc_state_t;

endpackage
